/* vga_pkg.sv */
package vga_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Raster coordinates.
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int COORD_W = 11;

  // Wide enough for the 1280 pixel line.
  typedef logic [COORD_W-1:0] coord_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Sprite FSM.
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    SPR_WAIT       = 2'd0,
    SPR_STEP_DOWN  = 2'd1,
    SPR_STEP_RIGHT = 2'd2,
    SPR_WRAP       = 2'd3
  } sprite_state_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // Default 800x600 at 60 Hz, 40 MHz pixel clock.
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int H_ACTIVE_DEF = 800;
  localparam int H_FRONT_DEF  = 40;
  localparam int H_SYNC_DEF   = 128;
  localparam int H_BACK_DEF   = 88;

  localparam int V_ACTIVE_DEF = 600;
  localparam int V_FRONT_DEF  = 1;
  localparam int V_SYNC_DEF   = 4;
  localparam int V_BACK_DEF   = 23;

endpackage

/* color_pkg.sv */
package color_pkg;

  typedef enum logic [1:0] {
    COLOR_BLACK = 2'd0,
    COLOR_RED   = 2'd1,
    COLOR_GREEN = 2'd2,
    COLOR_BLUE  = 2'd3
  } color_e;

  // Four bits per channel, red in the top nibble.
  localparam int RGB_W = 12;

  localparam logic [RGB_W-1:0] SPRITE_RGB = 12'hFFF;

  function automatic logic [RGB_W-1:0] palette( color_e color );
    logic [RGB_W-1:0] rgb;
    case( color )
      COLOR_RED:   rgb = 12'hF00;
      COLOR_GREEN: rgb = 12'h0F0;
      COLOR_BLUE:  rgb = 12'h00F;
      default:     rgb = 12'h000;
    endcase
    return rgb;
  endfunction

endpackage

/* vga_timing.sv */
`timescale 1ns/1ps

module vga_timing
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 800,
  parameter int H_FRONT  = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BACK   = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BACK   = 23
) (
  input  logic   clk40mhz,
  input  logic   arstn_i,

  output coord_t pix_x_o,
  output coord_t pix_y_o,
  output logic   active_o,
  output logic   hsync_o,
  output logic   vsync_o,
  output logic   frame_start_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam coord_t H_LAST       = coord_t'( H_TOTAL - 1 );
  localparam coord_t V_LAST       = coord_t'( V_TOTAL - 1 );
  localparam coord_t H_SYNC_START = coord_t'( H_ACTIVE + H_FRONT );
  localparam coord_t H_SYNC_END   = coord_t'( H_ACTIVE + H_FRONT + H_SYNC );
  localparam coord_t V_SYNC_START = coord_t'( V_ACTIVE + V_FRONT );
  localparam coord_t V_SYNC_END   = coord_t'( V_ACTIVE + V_FRONT + V_SYNC );

  coord_t h_cnt_ff;
  coord_t v_cnt_ff;
  logic   line_end;

  assign line_end = ( h_cnt_ff == H_LAST );

  // ~~~~~~~~~~~~~~~~~~~~
  // Counters.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      h_cnt_ff <= '0;
    end else if( line_end ) begin
      h_cnt_ff <= '0;
    end else begin
      h_cnt_ff <= h_cnt_ff + 1'b1;
    end
  end

  // One line per wrap of the pixel counter.
  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      v_cnt_ff <= '0;
    end else if( line_end ) begin
      if( v_cnt_ff == V_LAST ) begin
        v_cnt_ff <= '0;
      end else begin
        v_cnt_ff <= v_cnt_ff + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Decode.
  // ~~~~~~~~~~~~~~~~~~~~

  assign pix_x_o = h_cnt_ff;
  assign pix_y_o = v_cnt_ff;

  assign active_o = ( h_cnt_ff < coord_t'( H_ACTIVE ) ) &&
                    ( v_cnt_ff < coord_t'( V_ACTIVE ) );

  // Sync pulses are active high.
  assign hsync_o = ( h_cnt_ff >= H_SYNC_START ) && ( h_cnt_ff < H_SYNC_END );
  assign vsync_o = ( v_cnt_ff >= V_SYNC_START ) && ( v_cnt_ff < V_SYNC_END );

  assign frame_start_o = ( h_cnt_ff == '0 ) && ( v_cnt_ff == '0 );

endmodule

/* sprite_ctrl.sv */
`timescale 1ns/1ps

module sprite_ctrl
  import vga_pkg::*;
#(
  parameter int H_ACTIVE    = 800,
  parameter int V_ACTIVE    = 600,
  parameter int SPRITE_SIZE = 100,
  parameter int X_STEP      = 4,
  parameter int MOVE_DIVIDE = 1
) (
  input  logic   clk40mhz,
  input  logic   arstn_i,

  input  logic   frame_start_i,
  input  logic   sprite_en_i,

  output coord_t sprite_x_o,
  output coord_t sprite_y_o
);

  localparam int     DIV_W = ( MOVE_DIVIDE > 1 ) ? $clog2( MOVE_DIVIDE ) : 1;
  localparam coord_t X_MAX = coord_t'( H_ACTIVE - SPRITE_SIZE );
  localparam coord_t Y_MAX = coord_t'( V_ACTIVE - SPRITE_SIZE );

  logic [DIV_W-1:0] div_cnt_ff;
  logic             div_last;
  logic             step_req;

  sprite_state_e    state_ff;
  coord_t           pos_x_ff;
  coord_t           pos_y_ff;
  coord_t           sprite_x_ff;
  coord_t           sprite_y_ff;

  assign div_last = ( div_cnt_ff == DIV_W'( MOVE_DIVIDE - 1 ) );
  assign step_req = frame_start_i && sprite_en_i && div_last;

  // Frame divider holds while disabled.
  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      div_cnt_ff <= '0;
    end else if( frame_start_i && sprite_en_i ) begin
      div_cnt_ff <= div_last ? '0 : div_cnt_ff + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Motion FSM on the working position.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      state_ff <= SPR_WAIT;
      pos_x_ff <= '0;
      pos_y_ff <= '0;
    end else begin
      case( state_ff )
        SPR_WAIT: begin
          if( step_req ) state_ff <= SPR_STEP_DOWN;
        end
        SPR_STEP_DOWN: begin
          if( pos_y_ff + 1'b1 > Y_MAX ) begin
            pos_y_ff <= '0;
            state_ff <= SPR_STEP_RIGHT;
          end else begin
            pos_y_ff <= pos_y_ff + 1'b1;
            state_ff <= SPR_WAIT;
          end
        end
        SPR_STEP_RIGHT: begin
          if( pos_x_ff + coord_t'( X_STEP ) > X_MAX ) begin
            state_ff <= SPR_WRAP;
          end else begin
            pos_x_ff <= pos_x_ff + coord_t'( X_STEP );
            state_ff <= SPR_WAIT;
          end
        end
        default: begin
          pos_x_ff <= '0;
          state_ff <= SPR_WAIT;
        end
      endcase
    end
  end

  // Position seen by the pixel stage, fixed for a whole frame.
  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      sprite_x_ff <= '0;
      sprite_y_ff <= '0;
    end else if( frame_start_i ) begin
      sprite_x_ff <= pos_x_ff;
      sprite_y_ff <= pos_y_ff;
    end
  end

  assign sprite_x_o = sprite_x_ff;
  assign sprite_y_o = sprite_y_ff;

endmodule

/* tile_buffer.sv */
`timescale 1ns/1ps

module tile_buffer
  import vga_pkg::*;
  import color_pkg::*;
#(
  parameter int H_ACTIVE   = 800,
  parameter int V_ACTIVE   = 600,
  parameter int TILE_SHIFT = 5
) (
  input  logic   clk40mhz,
  input  logic   arstn_i,

  input  logic   wr_en_i,
  input  coord_t wr_tile_x_i,
  input  coord_t wr_tile_y_i,
  input  color_e wr_color_i,

  input  coord_t pix_x_i,
  input  coord_t pix_y_i,
  output color_e tile_color_o
);

  // Partial tiles at the right and bottom edge still count.
  localparam int TILES_X  = ( H_ACTIVE + ( 1 << TILE_SHIFT ) - 1 ) >> TILE_SHIFT;
  localparam int TILES_Y  = ( V_ACTIVE + ( 1 << TILE_SHIFT ) - 1 ) >> TILE_SHIFT;
  localparam int TILE_NUM = TILES_X * TILES_Y;
  localparam int ADDR_W   = ( TILE_NUM > 1 ) ? $clog2( TILE_NUM ) : 1;

  color_e            tile_mem [TILE_NUM];
  color_e            tile_color_ff;

  logic              wr_in_grid;
  logic [ADDR_W-1:0] wr_idx;

  coord_t            rd_tx;
  coord_t            rd_ty;
  logic              rd_in_grid;
  logic [ADDR_W-1:0] rd_idx;

  assign wr_in_grid = ( wr_tile_x_i < coord_t'( TILES_X ) ) &&
                      ( wr_tile_y_i < coord_t'( TILES_Y ) );
  assign wr_idx     = ADDR_W'( wr_tile_y_i * TILES_X + wr_tile_x_i );

  assign rd_tx      = pix_x_i >> TILE_SHIFT;
  assign rd_ty      = pix_y_i >> TILE_SHIFT;
  assign rd_in_grid = ( rd_tx < coord_t'( TILES_X ) ) && ( rd_ty < coord_t'( TILES_Y ) );
  assign rd_idx     = ADDR_W'( rd_ty * TILES_X + rd_tx );

  // Every tile starts black.
  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      for( int i = 0; i < TILE_NUM; i++ ) begin
        tile_mem[i] <= COLOR_BLACK;
      end
    end else if( wr_en_i && wr_in_grid ) begin
      tile_mem[wr_idx] <= wr_color_i;
    end
  end

  // Blanking coordinates fall off the grid, read black there.
  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      tile_color_ff <= COLOR_BLACK;
    end else begin
      tile_color_ff <= rd_in_grid ? tile_mem[rd_idx] : COLOR_BLACK;
    end
  end

  assign tile_color_o = tile_color_ff;

endmodule

/* pixel_out.sv */
`timescale 1ns/1ps

module pixel_out
  import vga_pkg::*;
  import color_pkg::*;
#(
  parameter int SPRITE_SIZE = 100
) (
  input  logic             clk40mhz,
  input  logic             arstn_i,

  input  coord_t           pix_x_i,
  input  coord_t           pix_y_i,
  input  logic             active_i,
  input  logic             hsync_i,
  input  logic             vsync_i,
  input  coord_t           sprite_x_i,
  input  coord_t           sprite_y_i,
  input  color_e           tile_color_i,

  output logic [RGB_W-1:0] rgb_o,
  output logic             hsync_o,
  output logic             vsync_o
);

  coord_t           x_d_ff;
  coord_t           y_d_ff;
  logic             active_d_ff;
  logic             hsync_d_ff;
  logic             vsync_d_ff;
  logic             sprite_hit;

  logic [RGB_W-1:0] rgb_ff;
  logic             hsync_ff;
  logic             vsync_ff;

  // ~~~~~~~~~~~~~~~~~~~~
  // Stage 1, alongside the tile read.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @( posedge clk40mhz ) begin
    x_d_ff <= pix_x_i;
    y_d_ff <= pix_y_i;
  end

  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      active_d_ff <= 1'b0;
      hsync_d_ff  <= 1'b0;
      vsync_d_ff  <= 1'b0;
    end else begin
      active_d_ff <= active_i;
      hsync_d_ff  <= hsync_i;
      vsync_d_ff  <= vsync_i;
    end
  end

  // Hit test on the delayed coordinate, so the corner loaded at frame start
  // covers the first pixel of the frame too.
  assign sprite_hit = ( x_d_ff >= sprite_x_i ) &&
                      ( x_d_ff <  sprite_x_i + coord_t'( SPRITE_SIZE ) ) &&
                      ( y_d_ff >= sprite_y_i ) &&
                      ( y_d_ff <  sprite_y_i + coord_t'( SPRITE_SIZE ) );

  // ~~~~~~~~~~~~~~~~~~~~
  // Stage 2, output register.
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @( posedge clk40mhz or negedge arstn_i ) begin
    if( ~arstn_i ) begin
      rgb_ff   <= '0;
      hsync_ff <= 1'b0;
      vsync_ff <= 1'b0;
    end else begin
      hsync_ff <= hsync_d_ff;
      vsync_ff <= vsync_d_ff;
      if( !active_d_ff ) begin
        rgb_ff <= '0;
      end else if( sprite_hit ) begin
        rgb_ff <= SPRITE_RGB;
      end else begin
        rgb_ff <= palette( tile_color_i );
      end
    end
  end

  assign rgb_o   = rgb_ff;
  assign hsync_o = hsync_ff;
  assign vsync_o = vsync_ff;

endmodule

/* vga_subsys_top.sv */
`timescale 1ns/1ps

module vga_subsys_top
  import vga_pkg::*;
  import color_pkg::*;
#(
  parameter int H_ACTIVE    = H_ACTIVE_DEF,
  parameter int H_FRONT     = H_FRONT_DEF,
  parameter int H_SYNC      = H_SYNC_DEF,
  parameter int H_BACK      = H_BACK_DEF,
  parameter int V_ACTIVE    = V_ACTIVE_DEF,
  parameter int V_FRONT     = V_FRONT_DEF,
  parameter int V_SYNC      = V_SYNC_DEF,
  parameter int V_BACK      = V_BACK_DEF,
  parameter int TILE_SHIFT  = 5,
  parameter int SPRITE_SIZE = 100,
  parameter int X_STEP      = 4,
  parameter int MOVE_DIVIDE = 1
) (
  input  logic             clk40mhz,
  input  logic             arstn_i,

  input  logic             wr_en_i,
  input  coord_t           wr_tile_x_i,
  input  coord_t           wr_tile_y_i,
  input  color_e           wr_color_i,
  input  logic             sprite_en_i,

  output logic [RGB_W-1:0] rgb_o,
  output logic             hsync_o,
  output logic             vsync_o
);

  coord_t pix_x;
  coord_t pix_y;
  logic   active;
  logic   hsync;
  logic   vsync;
  logic   frame_start;
  coord_t sprite_x;
  coord_t sprite_y;
  color_e tile_color;

  vga_timing #(
    .H_ACTIVE( H_ACTIVE ), .H_FRONT( H_FRONT ), .H_SYNC( H_SYNC ), .H_BACK( H_BACK ),
    .V_ACTIVE( V_ACTIVE ), .V_FRONT( V_FRONT ), .V_SYNC( V_SYNC ), .V_BACK( V_BACK )
  ) timing_i (
    .clk40mhz     ( clk40mhz    ),
    .arstn_i      ( arstn_i     ),
    .pix_x_o      ( pix_x       ),
    .pix_y_o      ( pix_y       ),
    .active_o     ( active      ),
    .hsync_o      ( hsync       ),
    .vsync_o      ( vsync       ),
    .frame_start_o( frame_start )
  );

  sprite_ctrl #(
    .H_ACTIVE( H_ACTIVE ), .V_ACTIVE( V_ACTIVE ), .SPRITE_SIZE( SPRITE_SIZE ),
    .X_STEP( X_STEP ), .MOVE_DIVIDE( MOVE_DIVIDE )
  ) sprite_i (
    .clk40mhz     ( clk40mhz    ),
    .arstn_i      ( arstn_i     ),
    .frame_start_i( frame_start ),
    .sprite_en_i  ( sprite_en_i ),
    .sprite_x_o   ( sprite_x    ),
    .sprite_y_o   ( sprite_y    )
  );

  tile_buffer #(
    .H_ACTIVE( H_ACTIVE ), .V_ACTIVE( V_ACTIVE ), .TILE_SHIFT( TILE_SHIFT )
  ) tiles_i (
    .clk40mhz    ( clk40mhz    ),
    .arstn_i     ( arstn_i     ),
    .wr_en_i     ( wr_en_i     ),
    .wr_tile_x_i ( wr_tile_x_i ),
    .wr_tile_y_i ( wr_tile_y_i ),
    .wr_color_i  ( wr_color_i  ),
    .pix_x_i     ( pix_x       ),
    .pix_y_i     ( pix_y       ),
    .tile_color_o( tile_color  )
  );

  pixel_out #(
    .SPRITE_SIZE( SPRITE_SIZE )
  ) pixel_i (
    .clk40mhz    ( clk40mhz   ),
    .arstn_i     ( arstn_i    ),
    .pix_x_i     ( pix_x      ),
    .pix_y_i     ( pix_y      ),
    .active_i    ( active     ),
    .hsync_i     ( hsync      ),
    .vsync_i     ( vsync      ),
    .sprite_x_i  ( sprite_x   ),
    .sprite_y_i  ( sprite_y   ),
    .tile_color_i( tile_color ),
    .rgb_o       ( rgb_o      ),
    .hsync_o     ( hsync_o    ),
    .vsync_o     ( vsync_o    )
  );

endmodule

/* tb_vga_checker.sv */
`timescale 1ns/1ps

module tb_vga_checker
  import vga_pkg::*;
  import color_pkg::*;
#(
  parameter int H_ACTIVE    = 16,
  parameter int H_FRONT     = 2,
  parameter int H_SYNC      = 3,
  parameter int H_BACK      = 3,
  parameter int V_ACTIVE    = 12,
  parameter int V_FRONT     = 1,
  parameter int V_SYNC      = 2,
  parameter int V_BACK      = 1,
  parameter int TILE_SHIFT  = 2,
  parameter int SPRITE_SIZE = 4,
  parameter int X_STEP      = 4,
  parameter int MOVE_DIVIDE = 2
) (
  input  logic         clk40mhz,
  input  logic         arstn_i,
  input  logic         wr_en_i,
  input  coord_t       wr_tile_x_i,
  input  coord_t       wr_tile_y_i,
  input  color_e       wr_color_i,
  input  logic         sprite_en_i,
  input  logic [11:0]  rgb_i,
  input  logic         hsync_i,
  input  logic         vsync_i,
  input  int           test_seq_i,
  input  logic [159:0] test_name_i,
  input  logic         done_i,
  output int           pass_cnt_o,
  output int           fail_cnt_o,
  output logic         closed_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int TILES_X = ( H_ACTIVE + ( 1 << TILE_SHIFT ) - 1 ) >> TILE_SHIFT;
  localparam int TILES_Y = ( V_ACTIVE + ( 1 << TILE_SHIFT ) - 1 ) >> TILE_SHIFT;

  color_e        tiles [TILES_X*TILES_Y];
  int            x_pos;
  int            y_pos;
  bit            locked;
  logic          hs_q;
  logic          vs_q;
  int            cyc;
  int            hs_rise;
  int            vs_rise;
  int            mod_x;
  int            mod_y;
  int            disp_x;
  int            disp_y;
  int            div_cnt;
  sprite_state_e last_step;
  logic [11:0]   exp_rgb;

  int            cur_seq;
  logic [159:0]  cur_name;
  int            err_cnt;
  string         err_what;
  int            err_exp;
  int            err_act;

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [11:0] color_rgb( color_e c );
    case( c )
      COLOR_RED:   return 12'hF00;
      COLOR_GREEN: return 12'h0F0;
      COLOR_BLUE:  return 12'h00F;
      default:     return 12'h000;
    endcase
  endfunction

  function automatic logic [11:0] expected_rgb( int x, int y );
    if( x >= H_ACTIVE || y >= V_ACTIVE ) return 12'h000;
    if( x >= disp_x && x < disp_x + SPRITE_SIZE &&
        y >= disp_y && y < disp_y + SPRITE_SIZE ) return 12'hFFF;
    return color_rgb( tiles[( y >> TILE_SHIFT ) * TILES_X + ( x >> TILE_SHIFT )] );
  endfunction

  task automatic move_sprite();
    if( mod_y + 1 > V_ACTIVE - SPRITE_SIZE ) begin
      mod_y = 0;
      if( mod_x + X_STEP > H_ACTIVE - SPRITE_SIZE ) begin
        mod_x     = 0;
        last_step = SPR_WRAP;
      end else begin
        mod_x     = mod_x + X_STEP;
        last_step = SPR_STEP_RIGHT;
      end
    end else begin
      mod_y     = mod_y + 1;
      last_step = SPR_STEP_DOWN;
    end
  endtask

  // Position shown in a frame is the one held at its start.
  task automatic begin_frame();
    disp_x = mod_x;
    disp_y = mod_y;
    if( sprite_en_i ) begin
      if( div_cnt == MOVE_DIVIDE - 1 ) begin
        div_cnt = 0;
        move_sprite();
      end else begin
        div_cnt = div_cnt + 1;
      end
    end
  endtask

  task automatic note_error( string what, int exp_val, int act_val );
    if( err_cnt == 0 ) begin
      err_what = what;
      err_exp  = exp_val;
      err_act  = act_val;
    end
    err_cnt = err_cnt + 1;
  endtask

  task automatic close_test();
    if( cur_seq > 0 ) begin
      if( err_cnt == 0 ) begin
        $display( "Pass %0s", cur_name );
        pass_cnt_o = pass_cnt_o + 1;
      end else begin
        $display( "Fail %0s %0s expected %0h actual %0h (%0d errors)",
                  cur_name, err_what, err_exp, err_act, err_cnt );
        fail_cnt_o = fail_cnt_o + 1;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Sampling.
  // ~~~~~~~~~~~~~~~~~~~~

  always @( posedge clk40mhz or negedge arstn_i ) begin
    if( !arstn_i ) begin
      for( int i = 0; i < TILES_X*TILES_Y; i++ ) begin
        tiles[i] = COLOR_BLACK;
      end
      x_pos      = 0;
      y_pos      = 0;
      locked     = 1'b0;
      hs_q       = 1'b0;
      vs_q       = 1'b0;
      cyc        = 0;
      hs_rise    = -1;
      vs_rise    = -1;
      mod_x      = 0;
      mod_y      = 0;
      disp_x     = 0;
      disp_y     = 0;
      div_cnt    = 0;
      last_step  = SPR_WAIT;
      cur_seq    = 0;
      cur_name   = '0;
      err_cnt    = 0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
      closed_o   = 1'b0;
    end else begin
      cyc = cyc + 1;

      if( !closed_o && test_seq_i != cur_seq ) begin
        close_test();
        cur_seq  = test_seq_i;
        cur_name = test_name_i;
        err_cnt  = 0;
      end
      if( done_i && !closed_o ) begin
        close_test();
        closed_o = 1'b1;
      end

      if( wr_en_i && int'( wr_tile_x_i ) < TILES_X && int'( wr_tile_y_i ) < TILES_Y ) begin
        tiles[int'( wr_tile_y_i ) * TILES_X + int'( wr_tile_x_i )] = wr_color_i;
      end

      // Pixel position rebuilt from the sync edges.
      if( hsync_i && !hs_q ) begin
        if( hs_rise >= 0 && cyc - hs_rise != H_TOTAL ) begin
          note_error( "hsync period", H_TOTAL, cyc - hs_rise );
        end
        hs_rise = cyc;
        x_pos   = H_ACTIVE + H_FRONT;
      end else begin
        x_pos = x_pos + 1;
        if( x_pos == H_TOTAL ) begin
          x_pos = 0;
          y_pos = ( y_pos + 1 ) % V_TOTAL;
        end
      end
      if( !hsync_i && hs_q && hs_rise >= 0 && cyc - hs_rise != H_SYNC ) begin
        note_error( "hsync width", H_SYNC, cyc - hs_rise );
      end

      if( vsync_i && !vs_q ) begin
        if( vs_rise >= 0 && cyc - vs_rise != H_TOTAL * V_TOTAL ) begin
          note_error( "vsync period", H_TOTAL * V_TOTAL, cyc - vs_rise );
        end
        vs_rise = cyc;
        y_pos   = V_ACTIVE + V_FRONT;
        locked  = 1'b1;
      end
      if( !vsync_i && vs_q && vs_rise >= 0 && cyc - vs_rise != H_TOTAL * V_SYNC ) begin
        note_error( "vsync width", H_TOTAL * V_SYNC, cyc - vs_rise );
      end
      hs_q = hsync_i;
      vs_q = vsync_i;

      if( locked ) begin
        if( x_pos == 0 && y_pos == 0 ) begin
          begin_frame();
        end
        exp_rgb = expected_rgb( x_pos, y_pos );
        if( rgb_i !== exp_rgb ) begin
          note_error( $sformatf( "rgb at (%0d,%0d) sprite after %s", x_pos, y_pos,
                                 last_step.name() ), int'( exp_rgb ), int'( rgb_i ) );
        end
      end
    end
  end

endmodule

/* tb_vga_top.sv */
`timescale 1ns/1ps

module tb_vga_top
  import vga_pkg::*;
  import color_pkg::*;
();

  localparam int FRAME_CYCLES = ( 16 + 2 + 3 + 3 ) * ( 12 + 1 + 2 + 1 );

  logic         clk40mhz;
  logic         arstn;
  logic         wr_en;
  coord_t       wr_tile_x;
  coord_t       wr_tile_y;
  color_e       wr_color;
  logic         sprite_en;
  logic [11:0]  rgb;
  logic         hsync;
  logic         vsync;

  int           test_seq;
  logic [159:0] test_name;
  logic         done;
  int           pass_cnt;
  int           fail_cnt;
  logic         closed;
  bit           abort;

  vga_subsys_top #(
    .H_ACTIVE( 16 ), .H_FRONT( 2 ), .H_SYNC( 3 ), .H_BACK( 3 ),
    .V_ACTIVE( 12 ), .V_FRONT( 1 ), .V_SYNC( 2 ), .V_BACK( 1 ),
    .TILE_SHIFT( 2 ), .SPRITE_SIZE( 4 ), .X_STEP( 4 ), .MOVE_DIVIDE( 2 )
  ) dut_i (
    .clk40mhz   ( clk40mhz  ),
    .arstn_i    ( arstn     ),
    .wr_en_i    ( wr_en     ),
    .wr_tile_x_i( wr_tile_x ),
    .wr_tile_y_i( wr_tile_y ),
    .wr_color_i ( wr_color  ),
    .sprite_en_i( sprite_en ),
    .rgb_o      ( rgb       ),
    .hsync_o    ( hsync     ),
    .vsync_o    ( vsync     )
  );

  tb_vga_checker #(
    .H_ACTIVE( 16 ), .H_FRONT( 2 ), .H_SYNC( 3 ), .H_BACK( 3 ),
    .V_ACTIVE( 12 ), .V_FRONT( 1 ), .V_SYNC( 2 ), .V_BACK( 1 ),
    .TILE_SHIFT( 2 ), .SPRITE_SIZE( 4 ), .X_STEP( 4 ), .MOVE_DIVIDE( 2 )
  ) checker_i (
    .clk40mhz   ( clk40mhz  ),
    .arstn_i    ( arstn     ),
    .wr_en_i    ( wr_en     ),
    .wr_tile_x_i( wr_tile_x ),
    .wr_tile_y_i( wr_tile_y ),
    .wr_color_i ( wr_color  ),
    .sprite_en_i( sprite_en ),
    .rgb_i      ( rgb       ),
    .hsync_i    ( hsync     ),
    .vsync_i    ( vsync     ),
    .test_seq_i ( test_seq  ),
    .test_name_i( test_name ),
    .done_i     ( done      ),
    .pass_cnt_o ( pass_cnt  ),
    .fail_cnt_o ( fail_cnt  ),
    .closed_o   ( closed    )
  );

  initial begin
    clk40mhz = 1'b0;
    forever #4 clk40mhz = ~clk40mhz;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus tasks.
  // ~~~~~~~~~~~~~~~~~~~~

  // Returns in vertical blanking, right after the sync rises.
  task automatic wait_vsync_rise( output bit ok );
    logic prev;
    int   cnt;
    ok   = 1'b0;
    prev = vsync;
    cnt  = 0;
    while( !ok && cnt < 2 * FRAME_CYCLES ) begin
      @( posedge clk40mhz );
      if( vsync && !prev ) ok = 1'b1;
      prev = vsync;
      cnt  = cnt + 1;
    end
    if( !ok ) begin
      $display( "Timeout: no rising edge on vsync_o within %0d cycles", 2 * FRAME_CYCLES );
    end
  endtask

  task automatic write_tile( int x, int y, int c, output bit ok );
    int gap;
    wait_vsync_rise( ok );
    if( ok ) begin
      gap = int'( $urandom % 4 );
      repeat( gap + 1 ) @( negedge clk40mhz );
      wr_tile_x = coord_t'( x );
      wr_tile_y = coord_t'( y );
      wr_color  = color_e'( c[1:0] );
      wr_en     = 1'b1;
      @( negedge clk40mhz );
      wr_en     = 1'b0;
    end
  endtask

  task automatic set_sprite_enable( int v, output bit ok );
    wait_vsync_rise( ok );
    if( ok ) begin
      @( negedge clk40mhz );
      sprite_en = ( v != 0 );
    end
  endtask

  task automatic run_frames( int n, output bit ok );
    ok = 1'b1;
    for( int i = 0; i < n && ok; i++ ) begin
      wait_vsync_rise( ok );
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Main sequence.
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    int           fd;
    int           n;
    int           a;
    int           b;
    int           c;
    int           cnt;
    bit           ok;
    byte          cmd;
    string        line_s;
    logic [159:0] name_bits;

    void'( $urandom( 81 ) );
    arstn     = 1'b0;
    wr_en     = 1'b0;
    wr_tile_x = '0;
    wr_tile_y = '0;
    wr_color  = COLOR_BLACK;
    sprite_en = 1'b0;
    test_seq  = 0;
    test_name = '0;
    done      = 1'b0;
    abort     = 1'b0;

    repeat( 3 ) @( posedge clk40mhz );
    @( negedge clk40mhz );
    arstn = 1'b1;

    fd = $fopen( "vga_testdata.txt", "r" );
    if( fd == 0 ) begin
      $display( "Cannot open vga_testdata.txt" );
      abort = 1'b1;
    end else begin
      while( !abort && !$feof( fd ) ) begin
        n = $fgets( line_s, fd );
        if( n > 0 && line_s.len() > 0 ) begin
          cmd = line_s.getc( 0 );
          ok  = 1'b1;
          if( cmd == "T" ) begin
            name_bits = '0;
            n = $sscanf( line_s, "T %s", name_bits );
            @( negedge clk40mhz );
            test_name = name_bits;
            test_seq  = test_seq + 1;
          end else if( cmd == "W" ) begin
            n = $sscanf( line_s, "W %d %d %d", a, b, c );
            if( n == 3 ) write_tile( a, b, c, ok );
          end else if( cmd == "E" ) begin
            n = $sscanf( line_s, "E %d", a );
            if( n == 1 ) set_sprite_enable( a, ok );
          end else if( cmd == "F" ) begin
            n = $sscanf( line_s, "F %d", a );
            if( n == 1 ) run_frames( a, ok );
          end else begin
            n = 1;
          end
          if( n < 1 ) begin
            $display( "Malformed line in vga_testdata.txt: %0s", line_s );
            abort = 1'b1;
          end
          if( !ok ) abort = 1'b1;
        end
      end
      $fclose( fd );
    end

    @( negedge clk40mhz );
    done = 1'b1;
    cnt  = 0;
    while( !closed && cnt < 100 ) begin
      @( posedge clk40mhz );
      cnt = cnt + 1;
    end
    if( !closed ) begin
      $display( "Checker did not close the last test" );
      abort = 1'b1;
    end

    $display( "Tests passed %0d, failed %0d", pass_cnt, fail_cnt );
    if( abort || fail_cnt != 0 || pass_cnt == 0 ) begin
      $display( "TEST FAIL" );
    end else begin
      $display( "TEST PASS" );
    end
    $finish;
  end

endmodule

/* vga_testdata.txt */
# T name | W tile_x tile_y color | E sprite_enable | F frames
# Grid is 4x3 tiles, colors 0 black 1 red 2 green 3 blue.
T reset_black
F 2
T tile_write
W 0 0 1
W 3 2 2
W 1 1 3
W 4 0 1
W 0 3 2
F 2
T sprite_down
E 1
F 8
T sprite_wrap
F 80
T sprite_hold
E 0
F 6
T sync_blank
F 2

/* build.f */
vga_pkg.sv
color_pkg.sv
vga_timing.sv
sprite_ctrl.sv
tile_buffer.sv
pixel_out.sv
vga_subsys_top.sv
tb_vga_checker.sv
tb_vga_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_vga_top -f build.f -o sim_vga &&
./obj_dir/sim_vga | tee /dev/stderr | grep -q "TEST PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
